// File: hdl/trace_config.svh
//////////////////////////////////////////////////////////////////////
// Sizing macros for the trace unit
//////////////////////////////////////////////////////////////////////
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// Sequence id handed out at fetch
`define TRACE_ID_W       8

// Record table slots, indexed by the low id bits
// Must be a power of two no smaller than 5 so in-flight ids never collide
`define TRACE_SLOTS      8

`define TRACE_FIFO_DEPTH 8  // Completed records waiting for software
`define STALL_CNT_W      4  // Saturating decode stall counter

`endif

// File: hdl/trace_pkg.sv
//////////////////////////////////////////////////////////////////////
// Trace data types: sequence id, stage word, counters, trace record
//////////////////////////////////////////////////////////////////////
`include "trace_config.svh"

package trace_pkg;

    typedef logic [`TRACE_ID_W-1:0]  seq_id_t;     // Per-instruction sequence number
    typedef logic [15:0]             stage_word_t; // Value sampled from one stage
    typedef logic [`STALL_CNT_W-1:0] stall_cnt_t;  // Cycles held in decode

    // FIFO occupancy, 0 up to the full depth
    typedef logic [$clog2(`TRACE_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    // One record per retired instruction
    typedef struct packed {
        seq_id_t     id;
        stage_word_t pc;           // From fetch
        stage_word_t instr;        // Raw instruction word from decode
        stage_word_t exec_result;
        stage_word_t mem_data;
        stage_word_t wb_data;
        stall_cnt_t  stall_cycles;
    } trace_rec_t;

endpackage

// File: hdl/trace_regs_pkg.sv
//////////////////////////////////////////////////////////////////////
// APB register map of the trace unit: offsets and field layouts
//////////////////////////////////////////////////////////////////////
package trace_regs_pkg;

    typedef logic [31:0] apb_word_t;

    // Byte offsets
    localparam logic [7:0] REG_CTRL       = 8'h00; // RW
    localparam logic [7:0] REG_STATUS     = 8'h04; // RO
    localparam logic [7:0] REG_POP        = 8'h08; // Write pops the FIFO head
    localparam logic [7:0] REG_REC_ID     = 8'h10; // Head record fields, RO
    localparam logic [7:0] REG_REC_PC     = 8'h14;
    localparam logic [7:0] REG_REC_INSTR  = 8'h18;
    localparam logic [7:0] REG_REC_EXEC   = 8'h1C;
    localparam logic [7:0] REG_REC_MEM    = 8'h20;
    localparam logic [7:0] REG_REC_WB     = 8'h24;
    localparam logic [7:0] REG_REC_STALLS = 8'h28;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        clear_overflow; // Write one to clear, reads 0
        logic        enable;         // Start tracing
    } trace_ctrl_t;

    typedef struct packed {
        logic [21:0] rsvd;
        logic        empty;
        logic        overflow;  // Sticky, a record was dropped
        logic [7:0]  count;     // FIFO occupancy
    } trace_status_t;

endpackage

// File: hdl/stage_tracker.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Sequence id assignment and the per-stage id and valid shift chain
//////////////////////////////////////////////////////////////////////
module stage_tracker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enable,  // Admit new instructions into fetch
    input  logic               stall,   // Hold fetch and decode
    output logic               valid_f,
    output logic               valid_d,
    output logic               valid_e,
    output logic               valid_m,
    output logic               valid_w,
    output trace_pkg::seq_id_t id_f,
    output trace_pkg::seq_id_t id_d,
    output trace_pkg::seq_id_t id_e,
    output trace_pkg::seq_id_t id_m,
    output trace_pkg::seq_id_t id_w
);
    import trace_pkg::*;

    seq_id_t next_id; // Id for the next instruction to enter fetch

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_id <= '0;
            valid_f <= 1'b0;
            valid_d <= 1'b0;
            valid_e <= 1'b0;
            valid_m <= 1'b0;
            valid_w <= 1'b0;
            id_f    <= '0;
            id_d    <= '0;
            id_e    <= '0;
            id_m    <= '0;
            id_w    <= '0;
        end else begin
            // Memory and write-back always advance
            valid_m <= valid_e;
            id_m    <= id_e;
            valid_w <= valid_m;
            id_w    <= id_m;
            if (stall) begin
                // Fetch and decode hold with valid kept set so decode stalls are counted
                valid_e <= 1'b0; // Bubble
            end else begin
                valid_e <= valid_d;
                id_e    <= id_d;
                valid_d <= valid_f;
                id_d    <= id_f;
                valid_f <= enable;     // Disabled fetch drains the pipe
                if (enable) begin
                    id_f    <= next_id;
                    next_id <= next_id + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/record_table.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Per-id slot table of partial records, emits a record at write-back
//////////////////////////////////////////////////////////////////////
`include "trace_config.svh"

module record_table (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   valid_f,
    input  logic                   valid_d,
    input  logic                   valid_e,
    input  logic                   valid_m,
    input  logic                   valid_w,
    input  trace_pkg::seq_id_t     id_f,
    input  trace_pkg::seq_id_t     id_d,
    input  trace_pkg::seq_id_t     id_e,
    input  trace_pkg::seq_id_t     id_m,
    input  trace_pkg::seq_id_t     id_w,
    input  trace_pkg::stage_word_t fetch_pc,
    input  trace_pkg::stage_word_t decode_instr,
    input  trace_pkg::stage_word_t exec_result,
    input  trace_pkg::stage_word_t mem_data,
    input  trace_pkg::stage_word_t wb_data,
    output logic                   rec_valid,
    output trace_pkg::trace_rec_t  rec
);
    import trace_pkg::*;

    localparam int SLOT_W = $clog2(`TRACE_SLOTS);

    // Partial records, one array per field
    stage_word_t pc_q    [`TRACE_SLOTS];
    stage_word_t instr_q [`TRACE_SLOTS];
    stage_word_t exec_q  [`TRACE_SLOTS];
    stage_word_t mem_q   [`TRACE_SLOTS];
    stall_cnt_t  stall_q [`TRACE_SLOTS];

    logic [SLOT_W-1:0] slot_f, slot_d, slot_e, slot_m, slot_w;

    // Slot is the low part of the id
    assign slot_f = id_f[SLOT_W-1:0];
    assign slot_d = id_d[SLOT_W-1:0];
    assign slot_e = id_e[SLOT_W-1:0];
    assign slot_m = id_m[SLOT_W-1:0];
    assign slot_w = id_w[SLOT_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // Stage writes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (valid_f) begin
            pc_q[slot_f]    <= fetch_pc;
            stall_q[slot_f] <= '0;    // Fresh count for a new instruction
        end
        if (valid_d) begin
            instr_q[slot_d] <= decode_instr;
            if (stall && stall_q[slot_d] != '1)
                stall_q[slot_d] <= stall_q[slot_d] + 1'b1; // Saturates
        end
        if (valid_e)
            exec_q[slot_e] <= exec_result;
        if (valid_m)
            mem_q[slot_m] <= mem_data;
    end

    //////////////////////////////////////////////////////////////////////
    // Record assembly at write-back
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n)
            rec_valid <= 1'b0;
        else
            rec_valid <= valid_w;
    end

    always_ff @(posedge clk) begin
        if (valid_w) begin
            rec.id           <= id_w;
            rec.pc           <= pc_q[slot_w];
            rec.instr        <= instr_q[slot_w];
            rec.exec_result  <= exec_q[slot_w];
            rec.mem_data     <= mem_q[slot_w];
            rec.wb_data      <= wb_data;       // Taken live in the write-back cycle
            rec.stall_cycles <= stall_q[slot_w];
        end
    end

endmodule

// File: hdl/trace_fifo.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Record FIFO with occupancy count and sticky overflow
//////////////////////////////////////////////////////////////////////
`include "trace_config.svh"

module trace_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  trace_pkg::trace_rec_t push_rec,
    input  logic                  pop,
    input  logic                  clear_overflow,
    output trace_pkg::trace_rec_t head,
    output trace_pkg::fifo_cnt_t  count,
    output logic                  empty,
    output logic                  overflow
);
    import trace_pkg::*;

    localparam int PTR_W = $clog2(`TRACE_FIFO_DEPTH);

    trace_rec_t       mem_q [`TRACE_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr; // Wrap naturally, depth is a power of two
    logic             full, do_push, do_pop;

    assign empty   = (count == '0);
    assign full    = (count == fifo_cnt_t'(`TRACE_FIFO_DEPTH));
    assign do_pop  = pop && !empty;              // Pop on empty is ignored
    assign do_push = push && (!full || do_pop);  // Same-cycle pop frees a place
    assign head    = mem_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem_q[wr_ptr] <= push_rec;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + fifo_cnt_t'(do_push) - fifo_cnt_t'(do_pop);
            // A dropped record wins over a clear in the same cycle
            if (push && !do_push)
                overflow <= 1'b1;
            else if (clear_overflow)
                overflow <= 1'b0;
        end
    end

endmodule

// File: hdl/apb_trace_regs.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// APB slave: control, status, FIFO pop and head record readback
//////////////////////////////////////////////////////////////////////
module apb_trace_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [7:0]                paddr,
    input  trace_regs_pkg::apb_word_t pwdata,
    output trace_regs_pkg::apb_word_t prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  trace_pkg::trace_rec_t     head,
    input  trace_pkg::fifo_cnt_t      count,
    input  logic                      empty,
    input  logic                      overflow,
    output logic                      enable,
    output logic                      pop,
    output logic                      clear_overflow
);
    import trace_regs_pkg::*;

    logic          access;    // Access phase of a transfer
    logic          wr;
    logic          mapped;
    logic          read_only;
    trace_ctrl_t   wr_ctrl;   // Write data seen as CTRL fields
    trace_ctrl_t   ctrl_rd;
    trace_status_t status;

    assign access  = psel && penable;
    assign wr      = access && pwrite;
    assign wr_ctrl = trace_ctrl_t'(pwdata);
    assign pready  = 1'b1;   // Zero wait states

    //////////////////////////////////////////////////////////////////////
    // Address decode and error response
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        case (paddr)
            REG_CTRL, REG_POP: ;
            REG_STATUS, REG_REC_ID, REG_REC_PC, REG_REC_INSTR, REG_REC_EXEC,
            REG_REC_MEM, REG_REC_WB, REG_REC_STALLS:
                read_only = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    assign pslverr        = access && (!mapped || (pwrite && read_only));
    assign pop            = wr && (paddr == REG_POP);   // Any write data pops
    assign clear_overflow = wr && (paddr == REG_CTRL) && wr_ctrl.clear_overflow;

    always_ff @(posedge clk) begin
        if (!rst_n)
            enable <= 1'b0;
        else if (wr && paddr == REG_CTRL)
            enable <= wr_ctrl.enable;
    end

    //////////////////////////////////////////////////////////////////////
    // Read data
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ctrl_rd         = '0;
        ctrl_rd.enable  = enable;
        status          = '0;
        status.count    = 8'(count);
        status.overflow = overflow;
        status.empty    = empty;
    end

    always_comb begin
        case (paddr)
            REG_CTRL:       prdata = ctrl_rd;
            REG_STATUS:     prdata = status;
            REG_REC_ID:     prdata = apb_word_t'(head.id);   // Zero-extended
            REG_REC_PC:     prdata = apb_word_t'(head.pc);
            REG_REC_INSTR:  prdata = apb_word_t'(head.instr);
            REG_REC_EXEC:   prdata = apb_word_t'(head.exec_result);
            REG_REC_MEM:    prdata = apb_word_t'(head.mem_data);
            REG_REC_WB:     prdata = apb_word_t'(head.wb_data);
            REG_REC_STALLS: prdata = apb_word_t'(head.stall_cycles);
            default:        prdata = '0;  // POP and unmapped read as zero
        endcase
    end

endmodule

// File: hdl/pipeline_trace_top.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Pipeline trace unit top: tracker, record table, FIFO, APB registers
//////////////////////////////////////////////////////////////////////
module pipeline_trace_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // APB
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [7:0]                paddr,
    input  trace_regs_pkg::apb_word_t pwdata,
    output trace_regs_pkg::apb_word_t prdata,
    output logic                      pready,
    output logic                      pslverr,
    // CPU side
    input  logic                      stall,
    input  trace_pkg::stage_word_t    fetch_pc,
    input  trace_pkg::stage_word_t    decode_instr,
    input  trace_pkg::stage_word_t    exec_result,
    input  trace_pkg::stage_word_t    mem_data,
    input  trace_pkg::stage_word_t    wb_data
);
    import trace_pkg::*;

    logic       enable, pop, clear_overflow;
    logic       valid_f, valid_d, valid_e, valid_m, valid_w;
    seq_id_t    id_f, id_d, id_e, id_m, id_w;
    logic       rec_valid;
    trace_rec_t rec;
    trace_rec_t head;     // Oldest record in the FIFO
    fifo_cnt_t  count;
    logic       empty, overflow;

    stage_tracker stage_tracker_i (
        .clk, .rst_n, .enable, .stall,
        .valid_f, .valid_d, .valid_e, .valid_m, .valid_w,
        .id_f, .id_d, .id_e, .id_m, .id_w
    );

    record_table record_table_i (
        .clk, .rst_n, .stall,
        .valid_f, .valid_d, .valid_e, .valid_m, .valid_w,
        .id_f, .id_d, .id_e, .id_m, .id_w,
        .fetch_pc, .decode_instr, .exec_result, .mem_data, .wb_data,
        .rec_valid, .rec
    );

    // No back-pressure, a full FIFO drops the record
    trace_fifo trace_fifo_i (
        .clk, .rst_n,
        .push     (rec_valid),
        .push_rec (rec),
        .pop, .clear_overflow,
        .head, .count, .empty, .overflow
    );

    apb_trace_regs apb_trace_regs_i (
        .clk, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .head, .count, .empty, .overflow,
        .enable, .pop, .clear_overflow
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Testbench clock (40 ns) and synchronous reset source
//////////////////////////////////////////////////////////////////////
module tb_clock (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (2) @(posedge clk); // Two cycles in reset
        rst_n <= 1'b1;
    end

    always #20 clk = ~clk; // 40 ns period
endmodule

// File: testbench/tb_pipeline_trace.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Pipeline trace testbench with phase table, CPU shadow model and APB checks
//////////////////////////////////////////////////////////////////////
`include "trace_config.svh"

module tb_pipeline_trace;
    import trace_pkg::*;
    import trace_regs_pkg::*;

    typedef struct {
        string      name;
        int         cycles;    // Enabled cycles in the phase
        logic [7:0] mask;      // Stall pattern with bit i used on cycle i mod 8
        bit         use_lfsr;  // Stall bits from the LFSR instead
        bit         en;
        int         reads;     // Records to read where -1 reads all expected
    } phase_t;

    logic        clk, rst_n;
    logic        psel, penable, pwrite, pready, pslverr, stall;
    logic [7:0]  paddr;
    apb_word_t   pwdata, prdata;
    stage_word_t fetch_pc, decode_instr, exec_result, mem_data, wb_data;

    phase_t      rows [5];
    int          cycle_cnt, limit;
    // Shadow CPU state with index 0 at fetch and 4 at write-back
    logic        sh_v  [5];
    seq_id_t     sh_id [5];
    seq_id_t     sh_next;
    logic        sh_en;
    stall_cnt_t  scnt [2**`TRACE_ID_W];   // Decode stall cycles per id
    trace_rec_t  exp_q [$];               // Records expected in the FIFO
    logic        exp_ovf;
    // Stall source
    logic        stall_on, use_lfsr;
    logic [7:0]  stall_mask;
    int          stall_idx;
    logic [31:0] lfsr;

    tb_clock tb_clock_i (.clk, .rst_n);

    pipeline_trace_top pipeline_trace_top_i (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .stall, .fetch_pc, .decode_instr, .exec_result,
        .mem_data, .wb_data
    );

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // Taps 32, 22, 2, 1
        return {s[30:0], fb};
    endfunction

    function automatic trace_rec_t expected_rec(input seq_id_t id);
        trace_rec_t r;
        r.id           = id;
        r.pc           = stage_word_t'(id) << 2;
        r.instr        = 16'hA000 | stage_word_t'(id);
        r.exec_result  = stage_word_t'(id) + 16'h0100;
        r.mem_data     = stage_word_t'(id) + 16'h0200;
        r.wb_data      = stage_word_t'(id) + 16'h0300;
        r.stall_cycles = scnt[id];
        return r;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopping at first error");
    endtask

    // Follows the tracker rule on the values applied before this edge
    task automatic shadow_step();
        if (!rst_n) begin
            foreach (sh_v[i]) begin
                sh_v[i]  = 1'b0;
                sh_id[i] = '0;
            end
            sh_next = '0;
            sh_en   = 1'b0;
        end else begin
            if (sh_v[0])
                scnt[sh_id[0]] = '0;
            if (sh_v[1] && stall && scnt[sh_id[1]] != '1)
                scnt[sh_id[1]] = scnt[sh_id[1]] + 1'b1;
            if (sh_v[4]) begin
                if (exp_q.size() < `TRACE_FIFO_DEPTH)
                    exp_q.push_back(expected_rec(sh_id[4]));
                else
                    exp_ovf = 1'b1; // Record dropped by a full FIFO
            end
            sh_v[4]  = sh_v[3];
            sh_id[4] = sh_id[3];
            sh_v[3]  = sh_v[2];
            sh_id[3] = sh_id[2];
            if (stall) begin
                sh_v[2] = 1'b0; // Bubble into execute
            end else begin
                sh_v[2]  = sh_v[1];
                sh_id[2] = sh_id[1];
                sh_v[1]  = sh_v[0];
                sh_id[1] = sh_id[0];
                sh_v[0]  = sh_en;
                if (sh_en) begin
                    sh_id[0] = sh_next;
                    sh_next  = sh_next + 1'b1;
                end
            end
            if (psel && penable && pwrite && paddr == REG_CTRL)
                sh_en = pwdata[0];
        end
    endtask

    // One clock with timeout, shadow update, stage words and stall for the next cycle
    task automatic tick();
        logic sb;
        @(posedge clk);
        cycle_cnt++;
        if (cycle_cnt > limit) begin
            $display("timeout, run exceeded %0d cycles", limit);
            $display("Testbench failed");
            $fatal(1, "simulation timed out");
        end
        shadow_step();
        fetch_pc     <= stage_word_t'(sh_id[0]) << 2;
        decode_instr <= 16'hA000 | stage_word_t'(sh_id[1]);
        exec_result  <= stage_word_t'(sh_id[2]) + 16'h0100;
        mem_data     <= stage_word_t'(sh_id[3]) + 16'h0200;
        wb_data      <= stage_word_t'(sh_id[4]) + 16'h0300;
        sb = 1'b0;
        if (stall_on) begin
            if (use_lfsr) begin
                lfsr = lfsr_next(lfsr); // One step per bit taken
                sb   = lfsr[0];
            end else begin
                sb = stall_mask[stall_idx % 8];
            end
            stall_idx++;
        end
        stall <= sb;
    endtask

    task automatic idle_tick();
        tick();
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // APB access and compare tasks
    ////////////////////////////////////////////////////////////////////
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input apb_word_t wdata,
                            output apb_word_t rdata, output logic err);
        tick();                  // Setup
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        tick();                  // Access
        penable <= 1'b1;
        @(negedge clk);          // Outputs settled in mid access
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1)
            report_failure("pready was low during an APB access");
    endtask

    task automatic check_word(input string name, input apb_word_t exp, input apb_word_t act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_status(input string name, input trace_status_t exp,
                                input trace_status_t act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic check_rec(input string name, input trace_rec_t exp, input trace_rec_t act);
        if (act !== exp)
            report_failure($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
    endtask

    task automatic reg_read(input string name, input logic [7:0] addr, output apb_word_t d);
        logic err;
        apb_xfer(1'b0, addr, '0, d, err);
        check_word({name, "_pslverr"}, 32'd0, apb_word_t'(err));
    endtask

    task automatic reg_write(input string name, input logic [7:0] addr, input apb_word_t d,
                             input logic exp_err);
        apb_word_t rd;
        logic      err;
        apb_xfer(1'b1, addr, d, rd, err);
        check_word({name, "_pslverr"}, apb_word_t'(exp_err), apb_word_t'(err));
    endtask

    task automatic status_check(input string name);
        trace_status_t exp;
        apb_word_t     d;
        exp          = '0;
        exp.count    = 8'(exp_q.size());
        exp.overflow = exp_ovf;
        exp.empty    = (exp_q.size() == 0);
        reg_read(name, REG_STATUS, d);
        idle_tick();
        check_status(name, exp, trace_status_t'(d));
    endtask

    // Rebuild the head record field by field and then pop it
    task automatic read_record(input string name);
        trace_rec_t r;
        apb_word_t  d;
        reg_read(name, REG_REC_ID, d);
        r.id = seq_id_t'(d);
        reg_read(name, REG_REC_PC, d);
        r.pc = stage_word_t'(d);
        reg_read(name, REG_REC_INSTR, d);
        r.instr = stage_word_t'(d);
        reg_read(name, REG_REC_EXEC, d);
        r.exec_result = stage_word_t'(d);
        reg_read(name, REG_REC_MEM, d);
        r.mem_data = stage_word_t'(d);
        reg_read(name, REG_REC_WB, d);
        r.wb_data = stage_word_t'(d);
        reg_read(name, REG_REC_STALLS, d);
        r.stall_cycles = stall_cnt_t'(d);
        if (exp_q.size() == 0)
            report_failure($sformatf("%s: a record was read but none was expected", name));
        check_rec(name, exp_q.pop_front(), r);
        reg_write(name, REG_POP, 32'd0, 1'b0);
        idle_tick();
    endtask

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////
    initial begin
        apb_word_t d;
        logic      err;
        int        n;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        stall        = 1'b0;
        fetch_pc     = '0;
        decode_instr = '0;
        exec_result  = '0;
        mem_data     = '0;
        wb_data      = '0;
        stall_on     = 1'b0;
        use_lfsr     = 1'b0;
        stall_mask   = '0;
        stall_idx    = 0;
        lfsr         = 32'h93d175e9;
        exp_ovf      = 1'b0;
        cycle_cnt    = 0;
        foreach (scnt[i])
            scnt[i] = '0;
        rows[0] = '{"disabled_idle", 10, 8'h00, 1'b0, 1'b0, 0};
        rows[1] = '{"no_stall",       6, 8'h00, 1'b0, 1'b1, 6};
        rows[2] = '{"fixed_stall",   12, 8'h4C, 1'b0, 1'b1, 7};
        rows[3] = '{"lfsr_stall",     8, 8'h00, 1'b1, 1'b1, -1};
        rows[4] = '{"overflow",      11, 8'h00, 1'b0, 1'b1, `TRACE_FIFO_DEPTH};
        limit = 100 + 40; // Margin plus reset and closing checks
        foreach (rows[i])
            limit += rows[i].cycles + 40 + 20 * (rows[i].reads < 0 ? `TRACE_FIFO_DEPTH
                                                                    : rows[i].reads);

        while (rst_n !== 1'b1)
            idle_tick();
        idle_tick();
        reg_read("reset_ctrl", REG_CTRL, d);
        idle_tick();
        check_word("reset_ctrl", 32'd0, d);
        status_check("reset_status");

        foreach (rows[i]) begin
            stall_mask = rows[i].mask;
            use_lfsr   = rows[i].use_lfsr;
            stall_idx  = 0;
            if (rows[i].en) begin
                // Enable is live for exactly rows[i].cycles edges
                reg_write(rows[i].name, REG_CTRL, 32'd1, 1'b0);
                stall_on = 1'b1;
                repeat (rows[i].cycles - 2)
                    idle_tick();
                reg_write(rows[i].name, REG_CTRL, 32'd0, 1'b0);
                stall_on = 1'b0;
                idle_tick();
            end else begin
                repeat (rows[i].cycles)
                    idle_tick();
            end
            repeat (12)
                idle_tick(); // Drain the pipe into the FIFO
            status_check({rows[i].name, "_status"});
            n = (rows[i].reads < 0) ? exp_q.size() : rows[i].reads;
            repeat (n)
                read_record(rows[i].name);
            if (exp_ovf) begin
                reg_write("clear_overflow", REG_CTRL, 32'd2, 1'b0);
                idle_tick();
                exp_ovf = 1'b0;
            end
            status_check({rows[i].name, "_after_reads"});
        end

        // Error responses
        apb_xfer(1'b0, 8'h0C, '0, d, err);
        idle_tick();
        check_word("unmapped_read_err", 32'd1, apb_word_t'(err));
        reg_write("status_write", REG_STATUS, 32'hFFFF_FFFF, 1'b1);
        idle_tick();
        status_check("status_write_status");
        reg_read("status_write_ctrl", REG_CTRL, d);
        idle_tick();
        check_word("status_write_ctrl", 32'd0, d); // Rejected write left enable off
        reg_write("empty_pop", REG_POP, 32'd0, 1'b0);
        idle_tick();
        status_check("empty_pop_status");

        $display("Testbench passed");
        $finish;
    end
endmodule

// File: verilog.f
+incdir+hdl
hdl/trace_pkg.sv
hdl/trace_regs_pkg.sv
hdl/stage_tracker.sv
hdl/record_table.sv
hdl/trace_fifo.sv
hdl/apb_trace_regs.sv
hdl/pipeline_trace_top.sv
testbench/tb_clock.sv
testbench/tb_pipeline_trace.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the pipeline trace testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module tb_pipeline_trace -o sim_tb

# A fatal stop returns non-zero, tee keeps the log for the search below
./obj_dir/sim_tb | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi
echo "Simulation PASSED"
